//--- hw/char2noc.sv
`timescale 1ns/1ps
`default_nettype none

module char2noc (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  uart_tile_pkg::char_t   char_i,
   input  wire                    char_valid_i,
   output logic                   char_ready_o,
   output uart_tile_pkg::flit_t   flit_o,
   output logic                   flit_valid_o,
   input  wire                    flit_ready_i
);

   uart_tile_pkg::flit_t  flit_next;
   logic                  load;

   // Room when empty or when the held flit leaves now
   assign char_ready_o = ~flit_valid_o | flit_ready_i;
   assign load         = char_valid_i & char_ready_o;

   always_comb begin
      flit_next = '0;                            // Unused payload bits stay zero
      flit_next[uart_tile_pkg::TYPE_MSB:uart_tile_pkg::TYPE_LSB] =
         uart_tile_pkg::FLIT_TYPE_SINGLE;
      flit_next[uart_tile_pkg::DEST_MSB:uart_tile_pkg::DEST_LSB] = uart_tile_pkg::DEST_ID;
      flit_next[uart_tile_pkg::CLS_MSB:uart_tile_pkg::CLS_LSB]   = uart_tile_pkg::PKT_CLASS;
      flit_next[uart_tile_pkg::SRC_MSB:uart_tile_pkg::SRC_LSB]   = uart_tile_pkg::TILE_ID;
      flit_next[uart_tile_pkg::CHAR_MSB:uart_tile_pkg::CHAR_LSB] = char_i;
   end

   always_ff @(posedge clk) begin
      if (load) begin
         flit_o <= flit_next;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         flit_valid_o <= 1'b0;
      end else if (load) begin
         flit_valid_o <= 1'b1;
      end else if (flit_ready_i) begin
         flit_valid_o <= 1'b0;                   // Sent, nothing new behind it
      end
   end

   // Held flit must not change under back-pressure
   a_flit_stable : assert property (@(posedge clk) disable iff (!rst_n_i)
      (flit_valid_o && !flit_ready_i) |=> (flit_valid_o && $stable(flit_o)));

endmodule

`default_nettype wire

//--- hw/char_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module char_fifo (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  uart_tile_pkg::char_t   wr_data_i,
   input  wire                    wr_valid_i,
   output logic                   wr_ready_o,
   output uart_tile_pkg::char_t   rd_data_o,
   output logic                   rd_valid_o,
   input  wire                    rd_ready_i
);

   uart_tile_pkg::char_t               mem [uart_tile_pkg::FIFO_DEPTH];
   logic [uart_tile_pkg::FIFO_AW-1:0]  wr_ptr;
   logic [uart_tile_pkg::FIFO_AW-1:0]  rd_ptr;
   logic [uart_tile_pkg::FIFO_AW:0]    count;    // One extra bit for full
   logic                               full;
   logic                               push;
   logic                               pop;

   assign full       = (count == uart_tile_pkg::FIFO_DEPTH);
   assign rd_valid_o = (count != '0);
   assign rd_data_o  = mem[rd_ptr];              // Head entry, no read latency

   // Full FIFO still takes a write when the head leaves in the same cycle
   assign wr_ready_o = ~full | rd_ready_i;

   assign push = wr_valid_i & wr_ready_o;
   assign pop  = rd_valid_o & rd_ready_i;

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;             // Depth is a power of two
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Writer refused while full must hold, or its character is lost
   a_no_write_when_full : assert property (@(posedge clk) disable iff (!rst_n_i)
      (wr_valid_i && !wr_ready_o) |=> wr_valid_i);

   a_count_in_range : assert property (@(posedge clk) disable iff (!rst_n_i)
      count <= uart_tile_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

//--- hw/noc2char.sv
`timescale 1ns/1ps
`default_nettype none

module noc2char (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  uart_tile_pkg::flit_t   flit_i,
   input  wire                    flit_valid_i,
   output logic                   flit_ready_o,
   output uart_tile_pkg::char_t   char_o,
   output logic                   char_valid_o,
   input  wire                    char_ready_i
);

   uart_tile_pkg::flit_type_t flit_type;
   logic                      is_single;
   logic [7:0]                drop_cnt;       // Discarded multi-flit fragments

   assign flit_type = flit_i[uart_tile_pkg::TYPE_MSB:uart_tile_pkg::TYPE_LSB];
   assign is_single = (flit_type == uart_tile_pkg::FLIT_TYPE_SINGLE);

   // Character always in the low payload byte
   assign char_o       = flit_i[uart_tile_pkg::CHAR_MSB:uart_tile_pkg::CHAR_LSB];
   assign char_valid_o = flit_valid_i & is_single;

   // Other flit types are swallowed at once
   assign flit_ready_o = is_single ? char_ready_i : 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         drop_cnt <= '0;
      end else if (flit_valid_i && !is_single) begin
         drop_cnt <= drop_cnt + 8'd1;            // Wraps, only watched for change
      end
   end

   // A counted drop never forwards a character
   a_drop_no_char : assert property (@(posedge clk) disable iff (!rst_n_i)
      (drop_cnt != $past(drop_cnt)) |-> !$past(char_valid_o));

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  wire                    srx_i,
   output uart_tile_pkg::char_t   char_o,
   output logic                   char_strobe_o
);

   logic                      srx_meta;       // First synchronizer stage
   logic                      srx_sync;
   logic                      srx_prev;       // For edge detect
   logic                      fall;
   uart_tile_pkg::rx_state_t  state;
   uart_tile_pkg::baud_cnt_t  baud_cnt;
   logic [2:0]                bit_idx;
   uart_tile_pkg::char_t      shreg;
   logic                      mid_bit;

   assign fall    = srx_prev & ~srx_sync;
   assign mid_bit = (baud_cnt == uart_tile_pkg::BAUD_LAST);

   // Character is complete once in STOP
   assign char_o        = shreg;
   assign char_strobe_o = (state == uart_tile_pkg::RX_STOP) & mid_bit & srx_sync;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         srx_meta <= 1'b1;
         srx_sync <= 1'b1;
         srx_prev <= 1'b1;
      end else begin
         srx_meta <= srx_i;
         srx_sync <= srx_meta;
         srx_prev <= srx_sync;
      end
   end

   always_ff @(posedge clk) begin
      if (state == uart_tile_pkg::RX_DATA && mid_bit) begin
         shreg <= {srx_sync, shreg[7:1]};        // LSB arrives first
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state    <= uart_tile_pkg::RX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
      end else begin
         case (state)
            uart_tile_pkg::RX_IDLE: begin
               if (fall) begin
                  state    <= uart_tile_pkg::RX_START;
                  baud_cnt <= '0;
               end
            end
            uart_tile_pkg::RX_START: begin
               // Half a bit in, the centre of the start bit
               if (baud_cnt == uart_tile_pkg::BAUD_HALF) begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  if (srx_sync) begin
                     state <= uart_tile_pkg::RX_IDLE;   // Glitch, not a frame
                  end else begin
                     state <= uart_tile_pkg::RX_DATA;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_tile_pkg::RX_DATA: begin
               if (mid_bit) begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     state <= uart_tile_pkg::RX_STOP;
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_tile_pkg::RX_STOP: begin
               // Low stop bit is a framing error, no strobe
               if (mid_bit) begin
                  state    <= uart_tile_pkg::RX_IDLE;
                  baud_cnt <= '0;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: state <= uart_tile_pkg::RX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/uart_tile.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tile (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  uart_tile_pkg::flit_t   noc_in_flit_i,
   input  wire                    noc_in_valid_i,
   output logic                   noc_in_ready_o,
   output uart_tile_pkg::flit_t   noc_out_flit_o,
   output logic                   noc_out_valid_o,
   input  wire                    noc_out_ready_i,
   input  wire                    srx_i,
   output logic                   stx_o
);

   // NoC to serial
   uart_tile_pkg::char_t  in_char;
   logic                  in_char_valid;
   logic                  in_char_ready;
   uart_tile_pkg::char_t  tx_char;
   logic                  tx_char_valid;
   logic                  tx_char_ready;

   // Serial to NoC
   uart_tile_pkg::char_t  rx_char;
   logic                  rx_strobe;
   uart_tile_pkg::char_t  out_char;
   logic                  out_char_valid;
   logic                  out_char_ready;

   noc2char u_noc2char (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .flit_i       (noc_in_flit_i),
      .flit_valid_i (noc_in_valid_i),
      .flit_ready_o (noc_in_ready_o),
      .char_o       (in_char),
      .char_valid_o (in_char_valid),
      .char_ready_i (in_char_ready)
   );

   char_fifo u_tx_fifo (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .wr_data_i    (in_char),
      .wr_valid_i   (in_char_valid),
      .wr_ready_o   (in_char_ready),
      .rd_data_o    (tx_char),
      .rd_valid_o   (tx_char_valid),
      .rd_ready_i   (tx_char_ready)
   );

   uart_tx u_uart_tx (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .char_i       (tx_char),
      .char_valid_i (tx_char_valid),
      .char_ready_o (tx_char_ready),
      .stx_o        (stx_o)
   );

   uart_rx u_uart_rx (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .srx_i         (srx_i),
      .char_o        (rx_char),
      .char_strobe_o (rx_strobe)
   );

   char_fifo u_rx_fifo (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .wr_data_i    (rx_char),
      .wr_valid_i   (rx_strobe),
      .wr_ready_o   (),                          // Receiver cannot stall, overflow drops
      .rd_data_o    (out_char),
      .rd_valid_o   (out_char_valid),
      .rd_ready_i   (out_char_ready)
   );

   char2noc u_char2noc (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .char_i       (out_char),
      .char_valid_i (out_char_valid),
      .char_ready_o (out_char_ready),
      .flit_o       (noc_out_flit_o),
      .flit_valid_o (noc_out_valid_o),
      .flit_ready_i (noc_out_ready_i)
   );

endmodule

`default_nettype wire

//--- hw/uart_tile_pkg.sv
`default_nettype none

package uart_tile_pkg;

   typedef logic [33:0] flit_t;      // Type plus 32 bit payload
   typedef logic [1:0]  flit_type_t;
   typedef logic [7:0]  char_t;
   typedef logic [4:0]  dest_t;
   typedef logic [2:0]  cls_t;
   typedef logic [4:0]  src_t;

   // Field positions inside a flit
   localparam int TYPE_MSB = 33;
   localparam int TYPE_LSB = 32;
   localparam int DEST_MSB = 31;
   localparam int DEST_LSB = 27;
   localparam int CLS_MSB  = 26;
   localparam int CLS_LSB  = 24;
   localparam int SRC_MSB  = 23;
   localparam int SRC_LSB  = 19;
   localparam int CHAR_MSB = 7;
   localparam int CHAR_LSB = 0;

   localparam flit_type_t FLIT_TYPE_SINGLE = 2'd3; // Head and tail in one flit
   localparam src_t       TILE_ID          = 5'd4;
   localparam dest_t      DEST_ID          = 5'd0;
   localparam cls_t       PKT_CLASS        = 3'd2;

   localparam int CLKS_PER_BIT = 8;                 // Kept short for simulation
   localparam int BAUD_CW      = $clog2(CLKS_PER_BIT);
   typedef logic [BAUD_CW-1:0] baud_cnt_t;
   localparam baud_cnt_t BAUD_LAST      = baud_cnt_t'(CLKS_PER_BIT - 1);
   localparam baud_cnt_t BAUD_HALF      = baud_cnt_t'(CLKS_PER_BIT / 2 - 1);
   localparam baud_cnt_t BAUD_STOP_LAST = baud_cnt_t'(CLKS_PER_BIT - 2); // Idle cycle ends it

   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_AW    = 2;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

endpackage

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire                    clk,
   input  wire                    rst_n_i,
   input  uart_tile_pkg::char_t   char_i,
   input  wire                    char_valid_i,
   output logic                   char_ready_o,
   output logic                   stx_o
);

   uart_tile_pkg::tx_state_t  state;
   uart_tile_pkg::baud_cnt_t  baud_cnt;
   logic [2:0]                bit_idx;
   uart_tile_pkg::char_t      shreg;          // Remaining data bits, LSB next
   logic                      accept;
   logic                      bit_done;

   assign char_ready_o = (state == uart_tile_pkg::TX_IDLE);
   assign accept       = char_valid_i & char_ready_o;
   assign bit_done     = (baud_cnt == uart_tile_pkg::BAUD_LAST);

   always_ff @(posedge clk) begin
      if (accept) begin
         shreg <= char_i;
      end else if (bit_done && (state == uart_tile_pkg::TX_START ||
                                state == uart_tile_pkg::TX_DATA)) begin
         shreg <= shreg >> 1;                    // Next bit to position 0
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         state    <= uart_tile_pkg::TX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         stx_o    <= 1'b1;                       // Line idles high
      end else begin
         case (state)
            uart_tile_pkg::TX_IDLE: begin
               if (char_valid_i) begin
                  state    <= uart_tile_pkg::TX_START;
                  stx_o    <= 1'b0;              // Start bit next cycle
                  baud_cnt <= '0;
               end
            end
            uart_tile_pkg::TX_START: begin
               if (bit_done) begin
                  state    <= uart_tile_pkg::TX_DATA;
                  stx_o    <= shreg[0];
                  bit_idx  <= '0;
                  baud_cnt <= '0;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_tile_pkg::TX_DATA: begin
               if (bit_done) begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 3'd1;
                  if (bit_idx == 3'd7) begin
                     state <= uart_tile_pkg::TX_STOP;
                     stx_o <= 1'b1;              // Stop bit
                  end else begin
                     stx_o <= shreg[0];
                  end
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            uart_tile_pkg::TX_STOP: begin
               // One cycle short, the IDLE cycle completes the stop bit
               if (baud_cnt == uart_tile_pkg::BAUD_STOP_LAST) begin
                  state    <= uart_tile_pkg::TX_IDLE;
                  baud_cnt <= '0;
               end else begin
                  baud_cnt <= baud_cnt + 1'b1;
               end
            end
            default: state <= uart_tile_pkg::TX_IDLE;
         endcase
      end
   end

   a_idle_line_high : assert property (@(posedge clk) disable iff (!rst_n_i)
      (state == uart_tile_pkg::TX_IDLE) |-> stx_o);

endmodule

`default_nettype wire

//--- sources.f
hw/uart_tile_pkg.sv
hw/noc2char.sv
hw/char_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/char2noc.sv
hw/uart_tile.sv
verification/uart_tile_tb.sv

//--- verification/uart_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tile_tb;

   localparam int CLK_HALF     = 4;
   localparam int CLK_PERIOD   = 2 * CLK_HALF;
   localparam int BIT_CLKS     = uart_tile_pkg::CLKS_PER_BIT;
   localparam int QUIET_CYCLES = 200;                // Catches stray frames or flits
   localparam int N_SINGLE     = 16;
   localparam int N_MIXED      = 20;
   localparam int N_RX         = 8;
   localparam int N_BADSTOP    = 3;
   localparam int N_BURST      = 12;
   localparam int N_HELD       = uart_tile_pkg::FIFO_DEPTH + 1;
   localparam int TOTAL_CHARS  = N_SINGLE + N_MIXED + N_RX + 2 * N_BADSTOP + N_BURST + N_HELD;
   localparam int WATCHDOG_NS  = TOTAL_CHARS * 10 * BIT_CLKS * CLK_PERIOD * 3;

   logic                   clk = 1'b0;
   logic                   rst_n_i;
   uart_tile_pkg::flit_t   noc_in_flit_i;
   logic                   noc_in_valid_i;
   logic                   noc_in_ready_o;
   uart_tile_pkg::flit_t   noc_out_flit_o;
   logic                   noc_out_valid_o;
   logic                   noc_out_ready_i;
   logic                   srx_i;
   logic                   stx_o;

   uart_tile_pkg::char_t   exp_chars [$];            // Expected on stx_o, in order
   uart_tile_pkg::flit_t   exp_flits [$];            // Expected on NoC output, in order
   string                  cur_test = "reset";
   int                     err_count = 0;
   int                     test_err_start = 0;
   int                     tests_run = 0;
   int                     tests_failed = 0;
   logic                   saw_stall;                // noc_in_ready_o seen low
   logic                   hold_ready = 1'b0;        // Back-pressure on NoC output
   logic                   toggle_ready = 1'b0;
   logic                   held_valid = 1'b0;
   uart_tile_pkg::flit_t   held_flit;

   uart_tile dut (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .noc_in_flit_i   (noc_in_flit_i),
      .noc_in_valid_i  (noc_in_valid_i),
      .noc_in_ready_o  (noc_in_ready_o),
      .noc_out_flit_o  (noc_out_flit_o),
      .noc_out_valid_o (noc_out_valid_o),
      .noc_out_ready_i (noc_out_ready_i),
      .srx_i           (srx_i),
      .stx_o           (stx_o)
   );

   always #(CLK_HALF) clk = ~clk;

   task automatic check_char(input string name, input uart_tile_pkg::char_t exp,
                             input uart_tile_pkg::char_t act);
      if (exp !== act) begin
         err_count++;
         $display("Error: %s: expected char %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_flit(input string name, input uart_tile_pkg::flit_t exp,
                             input uart_tile_pkg::flit_t act);
      if (exp !== act) begin
         err_count++;
         $display("Error: %s: expected flit %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         err_count++;
         $display("Error: %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic report_fault(input string what);
      err_count++;
      $display("Error in test %s: %s", cur_test, what);
   endtask

   // Outgoing flit as the header layout defines it
   function automatic uart_tile_pkg::flit_t make_flit(input uart_tile_pkg::char_t c);
      make_flit = {uart_tile_pkg::FLIT_TYPE_SINGLE, uart_tile_pkg::DEST_ID,
                   uart_tile_pkg::PKT_CLASS, uart_tile_pkg::TILE_ID, 11'd0, c};
   endfunction

   // Called 1 ns after a rising edge, returns at the same phase
   task automatic send_flit(input uart_tile_pkg::flit_t f);
      if (f[uart_tile_pkg::TYPE_MSB:uart_tile_pkg::TYPE_LSB] ==
          uart_tile_pkg::FLIT_TYPE_SINGLE) begin
         exp_chars.push_back(f[7:0]);                // Only single flits make frames
      end
      noc_in_flit_i  = f;
      noc_in_valid_i = 1'b1;
      @(negedge clk);
      while (!noc_in_ready_o) begin
         saw_stall = 1'b1;
         @(negedge clk);
      end
      @(posedge clk);                                // Transfer edge
      #1;
      noc_in_valid_i = 1'b0;
   endtask

   // Start bit, 8 data bits LSB first, chosen stop bit, then two idle bits
   task automatic send_frame(input uart_tile_pkg::char_t c, input logic stop_bit);
      logic [9:0] bits;
      bits = {stop_bit, c, 1'b0};
      if (stop_bit) begin
         exp_flits.push_back(make_flit(c));
      end
      for (int i = 0; i < 10; i++) begin
         srx_i = bits[i];
         repeat (BIT_CLKS) @(posedge clk);
         #1;
      end
      srx_i = 1'b1;
      repeat (2 * BIT_CLKS) @(posedge clk);
      #1;
   endtask

   task automatic start_test(input string name);
      cur_test       = name;
      test_err_start = err_count;
   endtask

   task automatic end_test();
      while (exp_chars.size() != 0 || exp_flits.size() != 0) begin
         @(negedge clk);                             // Watchdog bounds this
      end
      repeat (QUIET_CYCLES) @(negedge clk);
      tests_run++;
      if (err_count == test_err_start) begin
         $display("test %s: ok", cur_test);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_test, err_count - test_err_start);
      end
      @(posedge clk);
      #1;
   endtask

   // Serial line monitor, samples near mid-bit on falling clock edges
   initial begin : tx_monitor
      uart_tile_pkg::char_t c;
      forever begin
         @(negedge stx_o);
         repeat (BIT_CLKS / 2) @(negedge clk);
         if (stx_o !== 1'b0) begin
            report_fault("start bit on stx_o did not stay low");
         end
         for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            c[i] = stx_o;                            // LSB first
         end
         repeat (BIT_CLKS) @(negedge clk);
         if (stx_o !== 1'b1) begin
            report_fault("stop bit on stx_o was low");
         end
         if (exp_chars.size() == 0) begin
            report_fault("frame on stx_o with no character expected");
         end else begin
            check_char(cur_test, exp_chars.pop_front(), c);
         end
      end
   end

   // NoC output monitor, handshake seen before the edge that completes it
   always @(negedge clk) begin
      if (rst_n_i) begin
         if (held_valid) begin
            if (!noc_out_valid_o) begin
               report_fault("noc_out_valid_o dropped while ready was low");
            end
            check_flit({cur_test, " hold"}, held_flit, noc_out_flit_o);
         end
         held_valid = noc_out_valid_o && !noc_out_ready_i;
         held_flit  = noc_out_flit_o;
         if (noc_out_valid_o && noc_out_ready_i) begin
            if (exp_flits.size() == 0) begin
               report_fault("flit on NoC output with none expected");
            end else begin
               check_flit(cur_test, exp_flits.pop_front(), noc_out_flit_o);
            end
         end
      end
   end

   initial begin : out_ready_driver
      noc_out_ready_i = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         if (hold_ready) begin
            noc_out_ready_i = 1'b0;
         end else if (toggle_ready) begin
            noc_out_ready_i = 1'($urandom_range(1, 0));
         end else begin
            noc_out_ready_i = 1'b1;
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Error: run timed out in test %s", cur_test);
      if (exp_chars.size() != 0) begin
         $display("%0d characters never came out on stx_o", exp_chars.size());
      end
      if (exp_flits.size() != 0) begin
         $display("%0d flits never came out on the NoC output", exp_flits.size());
      end
      $display("*** FAILED ***");
      $finish;
   end

   initial begin : main
      uart_tile_pkg::flit_t f;
      void'($urandom(17313));
      rst_n_i        = 1'b0;
      noc_in_flit_i  = '0;
      noc_in_valid_i = 1'b0;
      srx_i          = 1'b1;                         // Idle line
      saw_stall      = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst_n_i = 1'b1;

      start_test("reset");
      check_bit("reset stx_o", 1'b1, stx_o);
      check_bit("reset noc_out_valid_o", 1'b0, noc_out_valid_o);
      check_bit("reset noc_in_ready_o", 1'b1, noc_in_ready_o);
      end_test();

      start_test("single_flits");
      for (int i = 0; i < N_SINGLE; i++) begin
         f = {uart_tile_pkg::FLIT_TYPE_SINGLE, 32'($urandom)};
         send_flit(f);
         repeat ($urandom_range(3, 0)) begin
            @(posedge clk);
            #1;
         end
      end
      end_test();

      start_test("mixed_types");
      for (int i = 0; i < N_MIXED; i++) begin
         f = {2'($urandom_range(3, 0)), 32'($urandom)};  // Types 0-2 are dropped
         send_flit(f);
      end
      end_test();

      start_test("rx_frames");
      for (int i = 0; i < N_RX; i++) begin
         send_frame(8'($urandom), 1'b1);
      end
      end_test();

      start_test("rx_bad_stop");
      for (int i = 0; i < N_BADSTOP; i++) begin
         send_frame(8'($urandom), 1'b0);             // Framing error, no flit
         send_frame(8'($urandom), 1'b1);
      end
      end_test();

      start_test("tx_burst");
      saw_stall = 1'b0;
      for (int i = 0; i < N_BURST; i++) begin
         send_flit({uart_tile_pkg::FLIT_TYPE_SINGLE, 32'($urandom)});
      end
      if (!saw_stall) begin
         report_fault("noc_in_ready_o never went low during the burst");
      end
      end_test();

      start_test("rx_backpressure");
      hold_ready = 1'b1;
      @(posedge clk);
      #1;
      for (int i = 0; i < N_HELD; i++) begin
         send_frame(8'($urandom), 1'b1);
      end
      repeat (BIT_CLKS) @(posedge clk);
      #1;
      if (!noc_out_valid_o) begin
         report_fault("no flit waiting on the NoC output under back-pressure");
      end
      toggle_ready = 1'b1;                           // Random ready from here on
      hold_ready   = 1'b0;
      end_test();
      toggle_ready = 1'b0;

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire
